/* vlog.f */
src/cache_cfg_pkg.sv
src/mem_msg_pkg.sv
src/cache_ctrl.sv
src/cache_meta.sv
src/cache_dpath.sv
src/blocking_cache.sv
verif/cache_checker.sv
verif/cache_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vcache_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0

/* verif/cache_tb.sv */
// Testbench for the two-way blocking cache
// Random requests checked against a word-level reference model and a memory model
module cache_tb;

  import cache_cfg_pkg::*;
  import mem_msg_pkg::*;

  localparam int CLK_PERIOD    = 100;
  localparam int NUM_REQS      = 300;
  localparam int WATCHDOG_TIME = NUM_REQS * 60 * CLK_PERIOD;
  localparam int REQ_STREAM    = 0;
  localparam int MEM_STREAM    = 1;

  logic      clk;
  logic      reset;
  logic      cachereq_val;
  logic      cachereq_rdy;
  msg_type_t cachereq_type;
  addr_t     cachereq_addr;
  word_t     cachereq_data;
  logic      cacheresp_val;
  logic      cacheresp_rdy;
  msg_type_t cacheresp_type;
  word_t     cacheresp_data;
  logic      memreq_val;
  logic      memreq_rdy;
  msg_type_t memreq_type;
  addr_t     memreq_addr;
  line_t     memreq_data;
  logic      memresp_val;
  logic      memresp_rdy;
  line_t     memresp_data;

  // One LFSR stream for requests, one for the memory side
  logic [31:0] lfsr_state [2];
  word_t       mem_words [addr_t];
  word_t       ref_words [addr_t];
  int          mem_reads;
  int          mem_writes;
  addr_t       last_read_addr;
  // Address of the request in flight
  addr_t       active_addr;

  blocking_cache dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Random numbers, fill pattern and models
  // --------------------------------------------------------------------------
  function automatic word_t random_bits(int stream, int count);
    word_t bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      if (lfsr_state[stream][0]) begin
        lfsr_state[stream] = (lfsr_state[stream] >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state[stream] = lfsr_state[stream] >> 1;
      end
      bits = {bits[WORD_W-2:0], lfsr_state[stream][0]};
    end
    return bits;
  endfunction

  // Rotated and scrambled address, so every bit shows up
  function automatic word_t fill_word(addr_t addr);
    return {addr[23:0], addr[31:24]} ^ 32'h5a3c_96e1;
  endfunction

  function automatic word_t model_word(addr_t addr);
    return ref_words.exists(addr) ? ref_words[addr] : fill_word(addr);
  endfunction

  function automatic word_t memory_word(addr_t addr);
    return mem_words.exists(addr) ? mem_words[addr] : fill_word(addr);
  endfunction

  function automatic addr_t make_addr(logic [1:0] tag_sel, idx_t idx, word_sel_t word);
    tag_t tag;
    tag = {23'h0a_5c31, tag_sel};
    return {tag, idx, word, 2'b00};
  endfunction

  function automatic addr_t line_base(addr_t addr);
    return {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic abort_run(string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_type(string name, msg_type_t got, msg_type_t exp);
    if (got !== exp) abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // Latency counts edges from acceptance to the first edge with cacheresp_val
  task automatic issue_request(msg_type_t typ, addr_t addr, word_t data, output int latency);
    int    edges;
    logic  done;
    word_t r;
    active_addr    = addr;
    cachereq_val  <= 1'b1;
    cachereq_type <= typ;
    cachereq_addr <= addr;
    cachereq_data <= data;
    do @(posedge clk); while (!cachereq_rdy);
    cachereq_val <= 1'b0;
    r = random_bits(REQ_STREAM, 1);
    cacheresp_rdy <= r[0];
    edges   = 0;
    latency = 0;
    do begin
      @(posedge clk);
      edges++;
      if (cacheresp_val && latency == 0) latency = edges;
      done = cacheresp_val && cacheresp_rdy;
      if (!done) begin
        r = random_bits(REQ_STREAM, 1);
        cacheresp_rdy <= r[0];
      end
    end while (!done);
    cacheresp_rdy <= 1'b0;
    if (typ == MSG_WRITE) begin
      check_type("cacheresp_type", cacheresp_type, MSG_WRITE);
      check_word("cacheresp_data", cacheresp_data, '0);
      ref_words[addr] = data;
    end else begin
      check_type("cacheresp_type", cacheresp_type, MSG_READ);
      check_word("cacheresp_data", cacheresp_data, model_word(addr));
    end
  endtask

  // --------------------------------------------------------------------------
  // Memory model with random ready and response delay
  // --------------------------------------------------------------------------
  initial begin : memory_model
    word_t r;
    addr_t base;
    line_t resp_line;
    memreq_rdy   <= 1'b0;
    memresp_val  <= 1'b0;
    memresp_data <= '0;
    forever begin
      @(posedge clk);
      if (!reset && memreq_val && memreq_rdy) begin
        base       = memreq_addr;
        resp_line  = '0;
        memreq_rdy <= 1'b0;
        if (memreq_type == MSG_WRITE) begin
          mem_writes++;
          // Victim keeps its own tag but sits in the set of the request
          check_addr("memreq_addr", base,
                     {base[ADDR_W-1 -: TAG_W], active_addr[OFFSET_W +: IDX_W],
                      {OFFSET_W{1'b0}}});
          for (int w = 0; w < WORDS_PER_LINE; w++) begin
            check_word("memreq_data", memreq_data[w*WORD_W +: WORD_W],
                       model_word(base + addr_t'(4 * w)));
            mem_words[base + addr_t'(4 * w)] = memreq_data[w*WORD_W +: WORD_W];
          end
        end else begin
          mem_reads++;
          check_addr("memreq_addr", base, line_base(active_addr));
          last_read_addr = base;
          for (int w = 0; w < WORDS_PER_LINE; w++) begin
            resp_line[w*WORD_W +: WORD_W] = memory_word(base + addr_t'(4 * w));
          end
        end
        r = random_bits(MEM_STREAM, 2);
        repeat (r[1:0]) @(posedge clk);
        memresp_val  <= 1'b1;
        memresp_data <= resp_line;
        do @(posedge clk); while (!memresp_rdy);
        memresp_val <= 1'b0;
      end else begin
        r = random_bits(MEM_STREAM, 1);
        memreq_rdy <= r[0];
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    abort_run($sformatf("Timeout, the cache made no progress within %0d time units",
                        WATCHDOG_TIME));
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin : stimulus
    int        lat;
    int        count_before;
    addr_t     addr_a;
    addr_t     addr_b;
    addr_t     addr_c;
    word_t     r;
    word_t     data;
    msg_type_t typ;
    lfsr_state[REQ_STREAM] = 32'h3a80_3ecb;
    lfsr_state[MEM_STREAM] = 32'h3a80_3ecb;
    mem_reads     = 0;
    mem_writes    = 0;
    reset         <= 1'b1;
    cachereq_val  <= 1'b0;
    cachereq_type <= MSG_READ;
    cachereq_addr <= '0;
    cachereq_data <= '0;
    cacheresp_rdy <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_flag("cachereq_rdy", cachereq_rdy, 1'b1);
    check_flag("cacheresp_val", cacheresp_val, 1'b0);
    check_flag("memreq_val", memreq_val, 1'b0);

    // Immediate re-read hits without memory traffic
    addr_a = make_addr(2'd0, 3'd5, 2'd1);
    addr_b = make_addr(2'd1, 3'd5, 2'd2);
    addr_c = make_addr(2'd2, 3'd5, 2'd3);
    issue_request(MSG_READ, addr_a, '0, lat);
    count_before = mem_reads + mem_writes;
    issue_request(MSG_READ, addr_a, '0, lat);
    check_count("memory requests on hit", mem_reads + mem_writes - count_before, 0);
    check_count("hit latency", lat, 3);

    // A, B, A, C in one set leaves A resident and B replaced
    issue_request(MSG_READ, addr_b, '0, lat);
    issue_request(MSG_READ, addr_a, '0, lat);
    issue_request(MSG_READ, addr_c, '0, lat);
    count_before = mem_reads;
    issue_request(MSG_READ, addr_a, '0, lat);
    check_count("memory reads for A", mem_reads - count_before, 0);
    count_before = mem_reads;
    issue_request(MSG_READ, addr_b, '0, lat);
    check_count("memory reads for B", mem_reads - count_before, 1);
    check_addr("refill address for B", last_read_addr, line_base(addr_b));

    for (int n = 0; n < NUM_REQS; n++) begin
      r    = random_bits(REQ_STREAM, 1);
      typ  = msg_type_t'(r[0]);
      r    = random_bits(REQ_STREAM, 7);
      data = random_bits(REQ_STREAM, 32);
      issue_request(typ, make_addr(r[6:5], r[4:2], r[1:0]), data, lat);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* verif/cache_checker.sv */
// Bound assertions for the blocking cache
// Handshake payload stability and memory request alignment
module cache_checker (
  input logic                   clk,
  input logic                   reset,
  input logic                   cachereq_val,
  input logic                   cachereq_rdy,
  input cache_cfg_pkg::addr_t   cachereq_addr,
  input logic                   cacheresp_val,
  input logic                   cacheresp_rdy,
  input mem_msg_pkg::msg_type_t cacheresp_type,
  input cache_cfg_pkg::word_t   cacheresp_data,
  input logic                   memreq_val,
  input logic                   memreq_rdy,
  input mem_msg_pkg::msg_type_t memreq_type,
  input cache_cfg_pkg::addr_t   memreq_addr,
  input cache_cfg_pkg::line_t   memreq_data
);

  import cache_cfg_pkg::*;
  import mem_msg_pkg::*;

  // Request address as taken at the cache port
  addr_t accepted_addr;

  always_ff @(posedge clk) begin
    if (cachereq_val && cachereq_rdy) accepted_addr <= cachereq_addr;
  end

  // Response held until the testbench takes it
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=>
      cacheresp_val && $stable(cacheresp_type) && $stable(cacheresp_data))
    else $error("cache response changed while cacheresp_rdy was low");

  memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val && $stable(memreq_type) &&
      $stable(memreq_addr) && $stable(memreq_data))
    else $error("memory request changed while memreq_rdy was low");

  // Aligned line in the requested set, and the requested tag on a refill
  memreq_line: assert property (@(posedge clk) disable iff (reset)
    memreq_val |-> (memreq_addr[OFFSET_W-1:0] == '0) &&
      (memreq_addr[OFFSET_W +: IDX_W] == accepted_addr[OFFSET_W +: IDX_W]) &&
      (memreq_type == MSG_WRITE ||
       memreq_addr[ADDR_W-1 -: TAG_W] == accepted_addr[ADDR_W-1 -: TAG_W]))
    else $error("memory request address is not the expected aligned line");

  // Blocking cache takes no new request while a response is pending
  no_overlap: assert property (@(posedge clk) disable iff (reset)
    !(cachereq_rdy && cacheresp_val))
    else $error("cachereq_rdy high together with cacheresp_val");

endmodule

bind blocking_cache cache_checker checker_inst (.*);

/* src/blocking_cache.sv */
// Two-way blocking write-back cache with LRU replacement
// Ties together the controller, the metadata and the datapath
module blocking_cache (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cachereq_val,
  output logic                   cachereq_rdy,
  input  mem_msg_pkg::msg_type_t cachereq_type,
  input  cache_cfg_pkg::addr_t   cachereq_addr,
  input  cache_cfg_pkg::word_t   cachereq_data,
  output logic                   cacheresp_val,
  input  logic                   cacheresp_rdy,
  output mem_msg_pkg::msg_type_t cacheresp_type,
  output cache_cfg_pkg::word_t   cacheresp_data,
  output logic                   memreq_val,
  input  logic                   memreq_rdy,
  output mem_msg_pkg::msg_type_t memreq_type,
  output cache_cfg_pkg::addr_t   memreq_addr,
  output cache_cfg_pkg::line_t   memreq_data,
  input  logic                   memresp_val,
  output logic                   memresp_rdy,
  input  cache_cfg_pkg::line_t   memresp_data
);

  import cache_cfg_pkg::*;
  import mem_msg_pkg::*;

  // Controller to datapath and metadata
  logic cachereq_en;
  logic memresp_en;
  logic is_refill;
  logic is_evict;
  logic tag_wen;
  logic data_wen;
  logic read_data_en;
  logic valid_wen;
  logic dirty_wen;
  logic dirty_in;
  logic lru_wen;
  logic way_record_en;

  // Status back from metadata and datapath
  logic      hit;
  logic      victim_dirty;
  logic      way_sel;
  logic      tag_match_0;
  logic      tag_match_1;
  idx_t      req_idx;
  msg_type_t req_type;

  cache_ctrl ctrl (.*);

  cache_meta meta (.*);

  cache_dpath dpath (.*);

endmodule

/* src/cache_dpath.sv */
// Cache datapath with request registers and two-way tag and data arrays
// Merges write words, selects the response word, forms memory requests
module cache_dpath (
  input  logic                   clk,
  input  mem_msg_pkg::msg_type_t cachereq_type,
  input  cache_cfg_pkg::addr_t   cachereq_addr,
  input  cache_cfg_pkg::word_t   cachereq_data,
  output mem_msg_pkg::msg_type_t cacheresp_type,
  output cache_cfg_pkg::word_t   cacheresp_data,
  output mem_msg_pkg::msg_type_t memreq_type,
  output cache_cfg_pkg::addr_t   memreq_addr,
  output cache_cfg_pkg::line_t   memreq_data,
  input  cache_cfg_pkg::line_t   memresp_data,
  input  logic                   cachereq_en,
  input  logic                   memresp_en,
  input  logic                   is_refill,
  input  logic                   is_evict,
  input  logic                   tag_wen,
  input  logic                   data_wen,
  input  logic                   read_data_en,
  input  logic                   way_sel,
  output mem_msg_pkg::msg_type_t req_type,
  output cache_cfg_pkg::idx_t    req_idx,
  output logic                   tag_match_0,
  output logic                   tag_match_1
);

  import cache_cfg_pkg::*;
  import mem_msg_pkg::*;

  addr_t     req_addr;
  word_t     req_data;
  tag_t      req_tag;
  word_sel_t req_word;
  line_t     refill_line;
  line_t     read_line;
  line_t     cur_line;
  line_t     merged_line;
  tag_t      line_tag;
  logic [WORDS_PER_LINE-1:0] word_en;

  // Arrays indexed as [way][set], no reset on payload
  tag_t  tag_mem  [2][NUM_SETS];
  line_t data_mem [2][NUM_SETS];

  // --------------------------------------------------------------------------
  // Request and refill registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (cachereq_en) begin
      req_type <= cachereq_type;
      req_addr <= cachereq_addr;
      req_data <= cachereq_data;
    end
    if (memresp_en) refill_line <= memresp_data;
    if (read_data_en) read_line <= cur_line;
  end

  assign req_tag  = req_addr[ADDR_W-1 -: TAG_W];
  assign req_idx  = req_addr[OFFSET_W +: IDX_W];
  assign req_word = req_addr[OFFSET_W-1:2];

  assign tag_match_0 = (tag_mem[0][req_idx] == req_tag);
  assign tag_match_1 = (tag_mem[1][req_idx] == req_tag);

  // --------------------------------------------------------------------------
  // Array write, one word on a store or the whole line on a refill
  // --------------------------------------------------------------------------
  assign cur_line = data_mem[way_sel][req_idx];

  always_comb begin
    word_en           = '0;
    word_en[req_word] = 1'b1;
    merged_line       = cur_line;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      if (word_en[w]) merged_line[w*WORD_W +: WORD_W] = req_data;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_wen) tag_mem[way_sel][req_idx] <= req_tag;
    if (data_wen) data_mem[way_sel][req_idx] <= is_refill ? refill_line : merged_line;
  end

  // --------------------------------------------------------------------------
  // Response and memory request
  // --------------------------------------------------------------------------
  assign cacheresp_type = req_type;
  assign cacheresp_data = (req_type == MSG_WRITE) ? '0 : read_line[req_word*WORD_W +: WORD_W];

  // Victim line address on an evict, request line otherwise
  assign line_tag    = is_evict ? tag_mem[way_sel][req_idx] : req_tag;
  assign memreq_addr = {line_tag, req_idx, {OFFSET_W{1'b0}}};
  assign memreq_type = is_evict ? MSG_WRITE : MSG_READ;
  assign memreq_data = read_line;

endmodule

/* src/cache_meta.sv */
// Cache metadata with per-set valid, dirty and LRU bits
// Detects hits, picks the victim and records the way for the access
module cache_meta (
  input  logic                clk,
  input  logic                reset,
  input  cache_cfg_pkg::idx_t req_idx,
  input  logic                tag_match_0,
  input  logic                tag_match_1,
  input  logic                valid_wen,
  input  logic                dirty_wen,
  input  logic                dirty_in,
  input  logic                lru_wen,
  input  logic                way_record_en,
  output logic                hit,
  output logic                victim_dirty,
  output logic                way_sel
);

  import cache_cfg_pkg::*;

  // Indexed as [way][set]
  logic [1:0][NUM_SETS-1:0] valid_bits;
  logic [1:0][NUM_SETS-1:0] dirty_bits;
  // One bit per set naming the least recently used way
  logic [NUM_SETS-1:0]      lru_bits;

  logic hit_0;
  logic hit_1;
  logic lru_way;
  logic way_in;

  // --------------------------------------------------------------------------
  // Hit detection and victim choice
  // --------------------------------------------------------------------------
  assign hit_0   = valid_bits[0][req_idx] && tag_match_0;
  assign hit_1   = valid_bits[1][req_idx] && tag_match_1;
  assign hit     = hit_0 || hit_1;
  assign lru_way = lru_bits[req_idx];

  assign victim_dirty = dirty_bits[lru_way][req_idx];

  // Hitting way on a hit, else replace the LRU way
  assign way_in = hit ? hit_1 : lru_way;

  // --------------------------------------------------------------------------
  // Bit updates, all aimed at the recorded way
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
      lru_bits   <= '0;
      way_sel    <= 1'b0;
    end else begin
      if (valid_wen) valid_bits[way_sel][req_idx] <= 1'b1;
      if (dirty_wen) dirty_bits[way_sel][req_idx] <= dirty_in;
      // Other way becomes the next victim
      if (lru_wen) lru_bits[req_idx] <= !way_sel;
      if (way_record_en) way_sel <= way_in;
    end
  end

endmodule

/* src/cache_ctrl.sv */
// Blocking cache controller
// Sequences tag check, data access, refill, eviction and response
module cache_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cachereq_val,
  output logic                  cachereq_rdy,
  output logic                  cacheresp_val,
  input  logic                  cacheresp_rdy,
  output logic                  memreq_val,
  input  logic                  memreq_rdy,
  input  logic                  memresp_val,
  output logic                  memresp_rdy,
  input  mem_msg_pkg::msg_type_t req_type,
  input  logic                  hit,
  input  logic                  victim_dirty,
  output logic                  cachereq_en,
  output logic                  memresp_en,
  output logic                  is_refill,
  output logic                  is_evict,
  output logic                  tag_wen,
  output logic                  data_wen,
  output logic                  read_data_en,
  output logic                  valid_wen,
  output logic                  dirty_wen,
  output logic                  dirty_in,
  output logic                  lru_wen,
  output logic                  way_record_en
);

  import mem_msg_pkg::*;

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    READ_ACCESS,
    WRITE_ACCESS,
    WAIT,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_UPDATE,
    EVICT_PREP,
    EVICT_REQ,
    EVICT_WAIT
  } cache_state_t;

  cache_state_t state;
  cache_state_t state_next;
  logic [15:0]  cs;

  // --------------------------------------------------------------------------
  // State register and transitions
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:          if (cachereq_val) state_next = TAG_CHECK;
      TAG_CHECK: begin
        if (hit) begin
          state_next = (req_type == MSG_WRITE) ? WRITE_ACCESS : READ_ACCESS;
        end else begin
          // Dirty victim goes out to memory before the refill
          state_next = victim_dirty ? EVICT_PREP : REFILL_REQ;
        end
      end
      READ_ACCESS:   state_next = WAIT;
      WRITE_ACCESS:  state_next = WAIT;
      WAIT:          if (cacheresp_rdy) state_next = IDLE;
      REFILL_REQ:    if (memreq_rdy) state_next = REFILL_WAIT;
      REFILL_WAIT:   if (memresp_val) state_next = REFILL_UPDATE;
      // Replay the original access on the fresh line
      REFILL_UPDATE: state_next = (req_type == MSG_WRITE) ? WRITE_ACCESS : READ_ACCESS;
      EVICT_PREP:    state_next = EVICT_REQ;
      EVICT_REQ:     if (memreq_rdy) state_next = EVICT_WAIT;
      EVICT_WAIT:    if (memresp_val) state_next = REFILL_REQ;
      default:       state_next = IDLE;
    endcase
  end

  // --------------------------------------------------------------------------
  // Control table
  // --------------------------------------------------------------------------
  // Columns in groups of four
  //   cachereq_rdy  cacheresp_val  memreq_val    memresp_rdy
  //   cachereq_en   memresp_en     is_refill     is_evict
  //   tag_wen       data_wen       read_data_en  valid_wen
  //   dirty_wen     dirty_in       lru_wen       way_record_en
  always_comb begin
    case (state)
      IDLE:          cs = 16'b1000_1000_0000_0000;
      TAG_CHECK:     cs = 16'b0000_0000_0000_0001;
      READ_ACCESS:   cs = 16'b0000_0000_0010_0010;
      WRITE_ACCESS:  cs = 16'b0000_0000_1101_1110;
      WAIT:          cs = 16'b0100_0000_0000_0000;
      REFILL_REQ:    cs = 16'b0010_0000_0000_0000;
      REFILL_WAIT:   cs = 16'b0001_0100_0000_0000;
      REFILL_UPDATE: cs = 16'b0000_0010_1101_1000;
      EVICT_PREP:    cs = 16'b0000_0000_0010_0000;
      EVICT_REQ:     cs = 16'b0010_0001_0000_0000;
      EVICT_WAIT:    cs = 16'b0001_0000_0000_0000;
      default:       cs = 16'b0000_0000_0000_0000;
    endcase
  end

  assign {cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy,
          cachereq_en, memresp_en, is_refill, is_evict,
          tag_wen, data_wen, read_data_en, valid_wen,
          dirty_wen, dirty_in, lru_wen, way_record_en} = cs;

endmodule

/* src/mem_msg_pkg.sv */
// Message types for the cache and memory interfaces
// One encoding serves requests, responses and memory traffic
package mem_msg_pkg;

  // ------------------------------------------------------------------------
  // Request type
  // ------------------------------------------------------------------------

  // Reads return a word or a line, writes return no data
  typedef enum logic [0:0] {
    MSG_READ  = 1'b0,
    MSG_WRITE = 1'b1
  } msg_type_t;

endpackage

/* src/cache_cfg_pkg.sv */
// Cache geometry for the two-way blocking cache
// Sizes and the vector types for addresses, words and lines
package cache_cfg_pkg;

  // ------------------------------------------------------------------------
  // Geometry
  // ------------------------------------------------------------------------
  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
  localparam int NUM_SETS       = 8;

  // Address split: tag | index | byte offset
  localparam int OFFSET_W = $clog2(LINE_W / 8);
  localparam int IDX_W    = $clog2(NUM_SETS);
  localparam int TAG_W    = ADDR_W - IDX_W - OFFSET_W;

  // ------------------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------------------
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  // Word 0 sits in the low bits
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [IDX_W-1:0]  idx_t;
  typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

endpackage
